// ==== serial_link_pkg.sv ====
/*
  Shared widths, beat counts and packed types of the off-chip serial link.
  Every link module imports this package; the flit and payload structs
  fix the bit layout on the wires and in the framing.
*/
`default_nettype none

package serial_link_pkg;

  ////////////////////////////////////////////////////////////
  // Link geometry
  ////////////////////////////////////////////////////////////

  localparam int FlitDataSize = 32;
  localparam int NumLanes     = 8;

  // Header bit plus flit data
  localparam int PayloadBits  = FlitDataSize + 1;

  // Payload rounded up to whole lane-wide beats
  localparam int NumBeats     = (PayloadBits + NumLanes - 1) / NumLanes;
  localparam int FramedBits   = NumBeats * NumLanes;

  // Local clock cycles per beat, forwarded clock toggles mid-beat
  localparam int ClkDiv       = 4;

  localparam int BeatIdxWidth = (NumBeats > 1) ? $clog2(NumBeats) : 1;
  localparam int DivCntWidth  = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [FlitDataSize-1:0] flit_data_t;

  typedef struct packed {
    logic       valid;
    flit_data_t data;
  } flit_chan_t;

  // hdr is 0 for request and 1 for response
  typedef struct packed {
    logic       hdr;
    flit_data_t flit_data;
  } payload_t;

  typedef logic [NumLanes-1:0] lane_t;

endpackage : serial_link_pkg

`default_nettype wire

// ==== serial_link_bridge.sv ====
/*
  Bridge between the two flit channels and the single link.
  Transmit picks one valid channel round robin and tags it with the
  header bit. Receive steers each finished frame to req_o or rsp_o
  by that bit, one cycle after the frame completes.
*/
`default_nettype none

module serial_link_bridge (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::flit_chan_t req_i,
  input  serial_link_pkg::flit_chan_t rsp_i,
  output logic                        req_ready_o,
  output logic                        rsp_ready_o,
  input  logic                        tx_busy_i,
  output logic                        tx_req_o,
  output serial_link_pkg::payload_t   tx_payload_o,
  input  serial_link_pkg::payload_t   rx_payload_i,
  input  logic                        rx_frame_done_i,
  output serial_link_pkg::flit_chan_t req_o,
  output serial_link_pkg::flit_chan_t rsp_o
);

  import serial_link_pkg::*;

  logic       gnt_req;
  logic       gnt_rsp;
  logic       accept;
  logic       prio_rsp_q;
  logic       req_valid_q;
  logic       rsp_valid_q;
  flit_data_t rx_data_q;

  ////////////////////////////////////////////////////////////
  // Transmit arbitration
  ////////////////////////////////////////////////////////////

  // Request wins unless response is valid and holds the priority
  assign gnt_req = req_i.valid & (~rsp_i.valid | ~prio_rsp_q);
  assign gnt_rsp = rsp_i.valid & ~gnt_req;

  // With nothing valid both channels look ready
  assign req_ready_o = ~tx_busy_i & ~gnt_rsp;
  assign rsp_ready_o = ~tx_busy_i & ~gnt_req;

  assign tx_req_o = req_i.valid | rsp_i.valid;
  assign accept   = tx_req_o & ~tx_busy_i;

  always_comb begin
    tx_payload_o.hdr       = gnt_rsp;
    tx_payload_o.flit_data = gnt_rsp ? rsp_i.data : req_i.data;
  end

  // Hand priority to the channel that lost this acceptance
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_rsp_q <= 1'b0;
    end else if (accept) begin
      prio_rsp_q <= gnt_req;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive demultiplexing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      req_valid_q <= rx_frame_done_i & ~rx_payload_i.hdr;
      rsp_valid_q <= rx_frame_done_i & rx_payload_i.hdr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_frame_done_i) begin
      rx_data_q <= rx_payload_i.flit_data;
    end
  end

  assign req_o = '{valid: req_valid_q, data: rx_data_q};
  assign rsp_o = '{valid: rsp_valid_q, data: rx_data_q};

endmodule : serial_link_bridge

`default_nettype wire

// ==== serial_link_ctrl.sv ====
/*
  Control of the serial link.
  The transmit FSM spends ClkDiv cycles on each of NumBeats beats and
  strobes the transmitter to load, shift and toggle the forwarded clock.
  The receive side counts detected beats into fixed-length frames.
*/
`default_nettype none

module serial_link_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tx_req_i,
  output logic tx_busy_o,
  output logic tx_load_o,
  output logic tx_shift_o,
  output logic tx_toggle_o,
  input  logic rx_beat_i,
  output logic rx_frame_done_o
);

  import serial_link_pkg::*;

  typedef enum logic {
    StIdle,
    StSend
  } tx_state_e;

  tx_state_e               state_q;
  logic [DivCntWidth-1:0]  timer_q;
  logic [BeatIdxWidth-1:0] tx_beat_q;
  logic [BeatIdxWidth-1:0] rx_beat_q;
  logic                    beat_end;
  logic                    last_tx_beat;
  logic                    last_rx_beat;

  ////////////////////////////////////////////////////////////
  // Transmit FSM
  ////////////////////////////////////////////////////////////

  assign tx_busy_o    = (state_q == StSend);
  assign tx_load_o    = (state_q == StIdle) & tx_req_i;
  assign beat_end     = (timer_q == DivCntWidth'(ClkDiv - 1));
  assign last_tx_beat = (tx_beat_q == BeatIdxWidth'(NumBeats - 1));

  // Strobes lead the transmitter outputs by one cycle
  assign tx_shift_o  = tx_busy_o & beat_end;
  assign tx_toggle_o = tx_busy_o & (timer_q == DivCntWidth'(ClkDiv / 2 - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= StIdle;
      timer_q   <= '0;
      tx_beat_q <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (tx_req_i) begin
            state_q   <= StSend;
            timer_q   <= '0;
            tx_beat_q <= '0;
          end
        end
        StSend: begin
          if (beat_end) begin
            timer_q <= '0;
            if (last_tx_beat) begin
              state_q <= StIdle;
            end else begin
              tx_beat_q <= tx_beat_q + 1'b1;
            end
          end else begin
            timer_q <= timer_q + 1'b1;
          end
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive beat counter
  ////////////////////////////////////////////////////////////

  // Frames have a fixed length, so counting from reset keeps alignment
  assign last_rx_beat    = (rx_beat_q == BeatIdxWidth'(NumBeats - 1));
  assign rx_frame_done_o = rx_beat_i & last_rx_beat;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_beat_q <= '0;
    end else if (rx_beat_i) begin
      rx_beat_q <= last_rx_beat ? '0 : rx_beat_q + 1'b1;
    end
  end

endmodule : serial_link_ctrl

`default_nettype wire

// ==== serial_link_tx.sv ====
/*
  Transmit side of the DDR link.
  Holds the framed payload in a shift register whose lowest lane drives
  ddr_o, and a forwarded clock register that flips once per beat.
  All outputs change in the cycle after the matching control strobe.
*/
`default_nettype none

module serial_link_tx (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  serial_link_pkg::payload_t tx_payload_i,
  input  logic                      tx_load_i,
  input  logic                      tx_shift_i,
  input  logic                      tx_toggle_i,
  output serial_link_pkg::lane_t    ddr_o,
  output logic                      ddr_rcv_clk_o
);

  import serial_link_pkg::*;

  logic [FramedBits-1:0] shift_q;
  logic                  fwd_clk_q;

  ////////////////////////////////////////////////////////////
  // Beat shift register
  ////////////////////////////////////////////////////////////

  // Zero fill from the top so the lanes go quiet after the last beat
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q <= '0;
    end else if (tx_load_i) begin
      shift_q <= {{(FramedBits - PayloadBits){1'b0}}, tx_payload_i};
    end else if (tx_shift_i) begin
      shift_q <= {{NumLanes{1'b0}}, shift_q[FramedBits-1:NumLanes]};
    end
  end

  assign ddr_o = lane_t'(shift_q[NumLanes-1:0]);

  ////////////////////////////////////////////////////////////
  // Forwarded clock
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fwd_clk_q <= 1'b0;
    end else if (tx_toggle_i) begin
      fwd_clk_q <= ~fwd_clk_q;
    end
  end

  assign ddr_rcv_clk_o = fwd_clk_q;

endmodule : serial_link_tx

`default_nettype wire

// ==== serial_link_rx.sv ====
/*
  Receive side of the DDR link.
  The forwarded clock and the lanes pass two synchronizer flops. Each
  edge of the synchronized clock, rising or falling, captures one beat
  into a shift register that fills from the top, and raises rx_beat_o
  three cycles after the toggle on the pin.
*/
`default_nettype none

module serial_link_rx (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      ddr_rcv_clk_i,
  input  serial_link_pkg::lane_t    ddr_i,
  output logic                      rx_beat_o,
  output serial_link_pkg::payload_t rx_payload_o
);

  import serial_link_pkg::*;

  logic                  clk_meta_q;
  logic                  clk_sync_q;
  logic                  clk_prev_q;
  logic                  beat_q;
  logic                  edge_det;
  lane_t                 lane_meta_q;
  lane_t                 lane_sync_q;
  logic [FramedBits-1:0] shift_q;

  ////////////////////////////////////////////////////////////
  // Synchronizers and edge detection
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_meta_q <= 1'b0;
      clk_sync_q <= 1'b0;
      clk_prev_q <= 1'b0;
      beat_q     <= 1'b0;
    end else begin
      clk_meta_q <= ddr_rcv_clk_i;
      clk_sync_q <= clk_meta_q;
      clk_prev_q <= clk_sync_q;
      beat_q     <= edge_det;
    end
  end

  // Both edges carry data
  assign edge_det = clk_sync_q ^ clk_prev_q;

  // Lanes follow the same two-stage path as the clock
  always_ff @(posedge clk_i) begin
    lane_meta_q <= ddr_i;
    lane_sync_q <= lane_meta_q;
  end

  ////////////////////////////////////////////////////////////
  // Beat capture
  ////////////////////////////////////////////////////////////

  // First beat lands in the lowest lane once the frame is complete
  always_ff @(posedge clk_i) begin
    if (edge_det) begin
      shift_q <= {lane_sync_q, shift_q[FramedBits-1:NumLanes]};
    end
  end

  assign rx_beat_o    = beat_q;
  assign rx_payload_o = payload_t'(shift_q[PayloadBits-1:0]);

endmodule : serial_link_rx

`default_nettype wire

// ==== floo_serial_link.sv ====
/*
  Top level of the single-channel DDR serial link.
  Request and response flits enter through valid/ready ports, leave the
  chip as lane-wide beats with a forwarded clock, and come back from the
  far side as single-cycle strobes on req_o and rsp_o.
*/
`default_nettype none

module floo_serial_link (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::flit_chan_t req_i,
  input  serial_link_pkg::flit_chan_t rsp_i,
  output logic                        req_ready_o,
  output logic                        rsp_ready_o,
  output serial_link_pkg::flit_chan_t req_o,
  output serial_link_pkg::flit_chan_t rsp_o,
  input  logic                        ddr_rcv_clk_i,
  output logic                        ddr_rcv_clk_o,
  input  serial_link_pkg::lane_t      ddr_i,
  output serial_link_pkg::lane_t      ddr_o
);

  import serial_link_pkg::*;

  payload_t tx_payload;
  payload_t rx_payload;
  logic     tx_req;
  logic     tx_busy;
  logic     tx_load;
  logic     tx_shift;
  logic     tx_toggle;
  logic     rx_beat;
  logic     rx_frame_done;

  ////////////////////////////////////////////////////////////
  // Network side
  ////////////////////////////////////////////////////////////

  serial_link_bridge u_bridge (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .req_i           ( req_i         ),
    .rsp_i           ( rsp_i         ),
    .req_ready_o     ( req_ready_o   ),
    .rsp_ready_o     ( rsp_ready_o   ),
    .tx_busy_i       ( tx_busy       ),
    .tx_req_o        ( tx_req        ),
    .tx_payload_o    ( tx_payload    ),
    .rx_payload_i    ( rx_payload    ),
    .rx_frame_done_i ( rx_frame_done ),
    .req_o           ( req_o         ),
    .rsp_o           ( rsp_o         )
  );

  serial_link_ctrl u_ctrl (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .tx_req_i        ( tx_req        ),
    .tx_busy_o       ( tx_busy       ),
    .tx_load_o       ( tx_load       ),
    .tx_shift_o      ( tx_shift      ),
    .tx_toggle_o     ( tx_toggle     ),
    .rx_beat_i       ( rx_beat       ),
    .rx_frame_done_o ( rx_frame_done )
  );

  ////////////////////////////////////////////////////////////
  // Physical side
  ////////////////////////////////////////////////////////////

  serial_link_tx u_tx (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .tx_payload_i  ( tx_payload    ),
    .tx_load_i     ( tx_load       ),
    .tx_shift_i    ( tx_shift      ),
    .tx_toggle_i   ( tx_toggle     ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o )
  );

  serial_link_rx u_rx (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .ddr_i         ( ddr_i         ),
    .rx_beat_o     ( rx_beat       ),
    .rx_payload_o  ( rx_payload    )
  );

endmodule : floo_serial_link

`default_nettype wire

// ==== floo_serial_link_chk.sv ====
/*
  Bound checker for the serial link top level.
  Watches the ready window after each acceptance, the forwarded clock,
  the receive strobes and the quiet state during and after reset.
*/
`default_nettype none

module floo_serial_link_chk (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input serial_link_pkg::flit_chan_t req_i,
  input serial_link_pkg::flit_chan_t rsp_i,
  input logic                        req_ready_i,
  input logic                        rsp_ready_i,
  input serial_link_pkg::flit_chan_t req_out_i,
  input serial_link_pkg::flit_chan_t rsp_out_i,
  input serial_link_pkg::lane_t      ddr_i,
  input logic                        ddr_clk_i,
  input logic                        tx_busy_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import serial_link_pkg::*;

  int         fail_cnt = 0;
  logic       accept;
  logic       quiet;
  logic       clk_prev_q;
  logic [3:0] toggle_cnt_q;

  assign accept = (req_i.valid & req_ready_i) | (rsp_i.valid & rsp_ready_i);
  assign quiet  = ~req_out_i.valid & ~rsp_out_i.valid & (ddr_i == '0) & ~ddr_clk_i;

  // Forwarded clock toggles since the last acceptance
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_prev_q   <= 1'b0;
      toggle_cnt_q <= '0;
    end else begin
      clk_prev_q <= ddr_clk_i;
      if (accept) begin
        toggle_cnt_q <= '0;
      end else if (ddr_clk_i != clk_prev_q) begin
        toggle_cnt_q <= toggle_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_ready_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |=> (!req_ready_i && !rsp_ready_i) [*(NumBeats * ClkDiv)]
               ##1 (req_ready_i || rsp_ready_i))
    else begin
      fail_cnt++;
      $error("ready outputs not low for a whole frame after an acceptance");
    end

  a_toggle_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> ##(NumBeats * ClkDiv + 1) (toggle_cnt_q == 4'(NumBeats)))
    else begin
      fail_cnt++;
      $error("forwarded clock toggled %0d times in one frame", toggle_cnt_q);
    end

  a_idle_clock: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $changed(ddr_clk_i) |-> $past(tx_busy_i))
    else begin
      fail_cnt++;
      $error("forwarded clock toggled while the link was idle");
    end

  a_strobe_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_out_i.valid || rsp_out_i.valid) |=> !(req_out_i.valid || rsp_out_i.valid))
    else begin
      fail_cnt++;
      $error("output valid high in two consecutive cycles");
    end

  // Sampled values are settled once the first reset edge has passed
  a_reset_quiet: assert property (@(posedge clk_i)
    (!rst_n_i && $past(!rst_n_i)) |-> quiet)
    else begin
      fail_cnt++;
      $error("outputs not quiet during reset");
    end

  a_release_quiet: assert property (@(posedge clk_i) $rose(rst_n_i) |-> quiet)
    else begin
      fail_cnt++;
      $error("outputs not quiet right after reset");
    end

endmodule : floo_serial_link_chk

bind floo_serial_link floo_serial_link_chk u_chk (
  .clk_i       ( clk_i         ),
  .rst_n_i     ( rst_n_i       ),
  .req_i       ( req_i         ),
  .rsp_i       ( rsp_i         ),
  .req_ready_i ( req_ready_o   ),
  .rsp_ready_i ( rsp_ready_o   ),
  .req_out_i   ( req_o         ),
  .rsp_out_i   ( rsp_o         ),
  .ddr_i       ( ddr_o         ),
  .ddr_clk_i   ( ddr_rcv_clk_o ),
  .tx_busy_i   ( tx_busy       )
);

`default_nettype wire

// ==== tb_floo_serial_link.sv ====
/*
  Loopback testbench for the serial link top level.
  ddr_o feeds ddr_i, so every accepted flit returns on req_o or rsp_o.
  Queues of accepted flits check data, routing and order, while the
  bound checker covers ready timing, the forwarded clock and reset.
*/
`default_nettype none

module tb_floo_serial_link;

  timeunit 1ns;
  timeprecision 100ps;

  import serial_link_pkg::*;

  localparam int Seed          = 35;
  localparam int NumBoth       = 8;
  localparam int NumSingle     = 12;
  localparam int NumFlits      = 2 * NumBoth + 2 * NumSingle;
  localparam int TimeoutCycles = NumFlits * 30 + 200;

  logic       clk;
  logic       rst_n;
  flit_chan_t req_in;
  flit_chan_t rsp_in;
  logic       req_ready;
  logic       rsp_ready;
  flit_chan_t req_out;
  flit_chan_t rsp_out;
  logic       ddr_clk;
  lane_t      ddr;

  flit_data_t exp_req_q[$];
  flit_data_t exp_rsp_q[$];
  logic       order_q[$];
  logic       both_phase;
  int         both_accepts;
  int         mismatch_cnt;
  int         error_cnt;

  floo_serial_link u_floo_serial_link (
    .clk_i         ( clk       ),
    .rst_n_i       ( rst_n     ),
    .req_i         ( req_in    ),
    .rsp_i         ( rsp_in    ),
    .req_ready_o   ( req_ready ),
    .rsp_ready_o   ( rsp_ready ),
    .req_o         ( req_out   ),
    .rsp_o         ( rsp_out   ),
    .ddr_rcv_clk_i ( ddr_clk   ),
    .ddr_rcv_clk_o ( ddr_clk   ),
    .ddr_i         ( ddr       ),
    .ddr_o         ( ddr       )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("ERROR at %0t: timeout, flits still outstanding after %0d cycles",
             $time, TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Hold the flit until the rising edge that accepts it
  task automatic send_flit(input logic hdr, input flit_data_t flit);
    @(negedge clk);
    if (hdr) begin
      rsp_in = '{valid: 1'b1, data: flit};
    end else begin
      req_in = '{valid: 1'b1, data: flit};
    end
    do begin
      @(posedge clk);
    end while (!(hdr ? rsp_ready : req_ready));
  endtask

  task automatic release_channel(input logic hdr);
    @(negedge clk);
    if (hdr) begin
      rsp_in.valid = 1'b0;
    end else begin
      req_in.valid = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    mismatch_cnt++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic record_accept(input logic hdr, input flit_data_t flit);
    // Both channels stay valid here, so grants must alternate from request
    if (both_phase) begin
      assert (hdr == both_accepts[0])
        else report_mismatch($sformatf("acceptance %0d went to %s", both_accepts,
                                       hdr ? "response" : "request"));
      both_accepts++;
    end
    if (hdr) begin
      exp_rsp_q.push_back(flit);
    end else begin
      exp_req_q.push_back(flit);
    end
    order_q.push_back(hdr);
  endtask

  task automatic check_output(input logic hdr, input flit_data_t flit);
    logic       exp_hdr;
    flit_data_t exp_flit;
    if (order_q.size() == 0) begin
      error_cnt++;
      $display("ERROR at %0t: flit on %s with no flit outstanding", $time,
               hdr ? "rsp_o" : "req_o");
      return;
    end
    exp_hdr  = order_q.pop_front();
    exp_flit = exp_hdr ? exp_rsp_q.pop_front() : exp_req_q.pop_front();
    assert (hdr == exp_hdr)
      else report_mismatch($sformatf("flit left on %s, expected %s",
                                     hdr ? "rsp_o" : "req_o", exp_hdr ? "rsp_o" : "req_o"));
    assert (flit == exp_flit)
      else report_mismatch($sformatf("data %h, expected %h", flit, exp_flit));
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (req_in.valid && req_ready) record_accept(1'b0, req_in.data);
      if (rsp_in.valid && rsp_ready) record_accept(1'b1, rsp_in.data);
      if (req_out.valid) check_output(1'b0, req_out.data);
      if (rsp_out.valid) check_output(1'b1, rsp_out.data);
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed;
    int          total;
    seed = Seed;
    void'($urandom(seed));
    req_in       = '0;
    rsp_in       = '0;
    rst_n        = 1'b0;
    both_phase   = 1'b0;
    both_accepts = 0;
    mismatch_cnt = 0;
    error_cnt    = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    // Simultaneous traffic right after reset
    both_phase = 1'b1;
    fork
      begin
        repeat (NumBoth) send_flit(1'b0, $urandom());
        release_channel(1'b0);
      end
      begin
        repeat (NumBoth) send_flit(1'b1, $urandom());
        release_channel(1'b1);
      end
    join
    both_phase = 1'b0;

    repeat (NumSingle) begin
      send_flit(1'b0, $urandom());
      release_channel(1'b0);
      repeat ($urandom_range(0, 24)) @(negedge clk);
    end
    repeat (NumSingle) begin
      send_flit(1'b1, $urandom());
      release_channel(1'b1);
      repeat ($urandom_range(0, 24)) @(negedge clk);
    end

    while (order_q.size() != 0) @(posedge clk);
    // Idle stretch so a stray forwarded clock toggle would show up
    repeat (2 * NumBeats * ClkDiv) @(posedge clk);

    total = mismatch_cnt + error_cnt + u_floo_serial_link.u_chk.fail_cnt;
    $display("Errors: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatch_cnt, error_cnt, u_floo_serial_link.u_chk.fail_cnt);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_floo_serial_link

`default_nettype wire

// ==== filelist.f ====
serial_link_pkg.sv
serial_link_bridge.sv
serial_link_ctrl.sv
serial_link_tx.sv
serial_link_rx.sv
floo_serial_link.sv
floo_serial_link_chk.sv
tb_floo_serial_link.sv
